// File: verilog/stream_core_cfg.svh
`ifndef STREAM_CORE_CFG_SVH
`define STREAM_CORE_CFG_SVH

////////////////////////////////////////
// Instruction word
////////////////////////////////////////

`define INST_WIDTH      36  // Raw word from the host
`define OPCODE_WIDTH    4   // Top field of the word
`define IMM_WIDTH       20  // Signed immediate in the low bits

////////////////////////////////////////
// Storage
////////////////////////////////////////

`define IM_ADDR_WIDTH   8   // 256 program words
`define DATA_WIDTH      32  // Register and result width
`define REG_ADDR_WIDTH  4   // 16 registers

// Idle cycles from burst end to first replay address
`define IMEM_REPLAY_GAP 16

`endif

// File: verilog/stream_core_pkg.sv
`default_nettype none

`include "stream_core_cfg.svh"

package stream_core_pkg;

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////

    // Codes 9 to 15 are illegal and run as NOP
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        OP_NOP = 4'd0,
        OP_LDI = 4'd1,  // rd = sext(imm)
        OP_ADD = 4'd2,
        OP_SUB = 4'd3,
        OP_AND = 4'd4,
        OP_OR  = 4'd5,
        OP_XOR = 4'd6,
        OP_SHL = 4'd7,  // rd = ra << rb[4:0]
        OP_OUT = 4'd8   // Emit ra on the result port
    } opcode_e;

    ////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////

    // Word as loaded and replayed, op kept raw so illegal codes survive
    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0]   op;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] ra;
        logic [`REG_ADDR_WIDTH-1:0] rb;
        logic signed [`IMM_WIDTH-1:0] imm;
    } inst_t;

    typedef struct packed {
        opcode_e                    op;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] ra;
        logic [`REG_ADDR_WIDTH-1:0] rb;
        logic [`DATA_WIDTH-1:0]     imm;     // Already sign extended
        logic                       wr_reg;  // Write rd at execute
        logic                       emit;    // Drive the result port
    } uop_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0]     data;
        logic [`REG_ADDR_WIDTH-1:0] src;     // Register that was read
    } result_t;

endpackage

`default_nettype wire

// File: verilog/sdp_bram.sv
`default_nettype none

// Inferred simple dual port RAM
// Port A writes, port B reads through one output register
module sdp_bram
    import stream_core_pkg::*;
#(
    parameter int RAM_DEPTH = 256
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         wr_en,
    input  wire logic [$clog2(RAM_DEPTH)-1:0] wr_addr,
    input  wire inst_t                        wr_data,
    input  wire logic                         rd_en,
    input  wire logic [$clog2(RAM_DEPTH)-1:0] rd_addr,
    output inst_t                             rd_data
);

    inst_t mem [RAM_DEPTH];  // Block RAM array, contents survive reset

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    // One cycle read latency
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;  // Output register only
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/inst_mem.sv
`default_nettype none

`include "stream_core_cfg.svh"

// Loads a burst of words, waits out the gap, then replays the program once
module inst_mem
    import stream_core_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  inst_valid,
    output logic       inst_ready,
    input  wire inst_t inst,
    output logic       raw_valid,
    output inst_t      raw
);

    localparam int DEPTH  = 2 ** `IM_ADDR_WIDTH;
    localparam int GAP_CW = $clog2(`IMEM_REPLAY_GAP);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_GAP,
        ST_REPLAY
    } state_e;

    state_e                   state;
    logic [`IM_ADDR_WIDTH:0]  wr_cnt;   // Words stored, one extra bit for full
    logic [GAP_CW-1:0]        gap_cnt;
    logic [`IM_ADDR_WIDTH-1:0] pc;
    logic [`IM_ADDR_WIDTH-1:0] addr;
    logic                     accept;
    logic                     wr_en;
    logic                     rd_en;
    logic                     last_word;

    ////////////////////////////////////////
    // Handshake and address select
    ////////////////////////////////////////

    assign inst_ready = (state == ST_IDLE) || (state == ST_LOAD);
    assign accept     = inst_valid && inst_ready;
    assign wr_en      = accept && !wr_cnt[`IM_ADDR_WIDTH];  // Drop beats once full
    assign rd_en      = (state == ST_REPLAY);
    assign last_word  = ({1'b0, pc} == wr_cnt - 1'b1);

    assign addr = rd_en ? pc : wr_cnt[`IM_ADDR_WIDTH-1:0];  // Read or write

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    // Burst end cycle counts as the first idle cycle of the gap
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            wr_cnt  <= '0;
            gap_cnt <= '0;
            pc      <= '0;
        end else begin
            if (wr_en) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (accept) state <= ST_LOAD;  // First beat of a burst
                end
                ST_LOAD: begin
                    if (!inst_valid) begin  // Burst ends here
                        state   <= ST_GAP;
                        gap_cnt <= '0;
                    end
                end
                ST_GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == GAP_CW'(`IMEM_REPLAY_GAP - 2)) begin
                        state <= ST_REPLAY;
                        pc    <= '0;
                    end
                end
                ST_REPLAY: begin
                    if (last_word) begin
                        state  <= ST_IDLE;  // Ready again, count cleared
                        pc     <= '0;
                        wr_cnt <= '0;
                    end else begin
                        pc <= pc + 1'b1;  // Program counter
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Valid lines up with the RAM read latency
    always_ff @(posedge clk) begin
        if (rst) raw_valid <= 1'b0;
        else     raw_valid <= rd_en;
    end

    sdp_bram #(
        .RAM_DEPTH (DEPTH)
    ) u_bram (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (addr),
        .wr_data (inst),
        .rd_en   (rd_en),
        .rd_addr (addr),
        .rd_data (raw)
    );

endmodule

`default_nettype wire

// File: verilog/inst_decoder.sv
`default_nettype none

`include "stream_core_cfg.svh"

// One register stage from raw words to micro-ops
module inst_decoder
    import stream_core_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  raw_valid,
    input  wire inst_t raw,
    output logic       uop_valid,
    output uop_t       uop
);

    opcode_e op_raw;
    uop_t    nxt;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    assign op_raw = opcode_e'(raw.op);

    always_comb begin
        nxt     = '0;
        nxt.rd  = raw.rd;
        nxt.ra  = raw.ra;
        nxt.rb  = raw.rb;
        // Sign extend the immediate
        nxt.imm = {{(`DATA_WIDTH - `IMM_WIDTH){raw.imm[`IMM_WIDTH-1]}}, raw.imm};
        case (op_raw)
            OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL: begin
                nxt.op     = op_raw;
                nxt.wr_reg = 1'b1;  // All of these write rd
            end
            OP_OUT: begin
                nxt.op   = OP_OUT;
                nxt.emit = 1'b1;
            end
            default: begin
                nxt.op = OP_NOP;  // NOP and every illegal code
            end
        endcase
    end

    ////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) uop_valid <= 1'b0;
        else     uop_valid <= raw_valid;
    end

    // New word every cycle, payload only moves with valid
    always_ff @(posedge clk) begin
        if (raw_valid) begin
            uop <= nxt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/exec_unit.sv
`default_nettype none

`include "stream_core_cfg.svh"

// Register file, ALU and result port
module exec_unit
    import stream_core_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic uop_valid,
    input  wire uop_t uop,
    output logic      result_valid,
    output result_t   result
);

    localparam int NUM_REGS = 2 ** `REG_ADDR_WIDTH;
    localparam int SHW      = $clog2(`DATA_WIDTH);  // Shift amount bits

    logic [`DATA_WIDTH-1:0] rf [NUM_REGS];
    logic [`DATA_WIDTH-1:0] op_a;
    logic [`DATA_WIDTH-1:0] op_b;
    logic [`DATA_WIDTH-1:0] alu_out;
    logic                   do_write;
    logic                   do_emit;

    ////////////////////////////////////////
    // Operand read
    ////////////////////////////////////////

    // Combinational read, a write from the previous cycle is already visible
    assign op_a = rf[uop.ra];
    assign op_b = rf[uop.rb];

    assign do_write = uop_valid && uop.wr_reg;
    assign do_emit  = uop_valid && uop.emit;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (uop.op)
            OP_LDI:  alu_out = uop.imm;
            OP_ADD:  alu_out = op_a + op_b;  // Wraps
            OP_SUB:  alu_out = op_a - op_b;  // Wraps
            OP_AND:  alu_out = op_a & op_b;
            OP_OR:   alu_out = op_a | op_b;
            OP_XOR:  alu_out = op_a ^ op_b;
            OP_SHL:  alu_out = op_a << op_b[SHW-1:0];  // Low 5 bits only
            default: alu_out = '0;  // NOP and OUT write nothing
        endcase
    end

    ////////////////////////////////////////
    // Register file write
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (do_write) begin
            rf[uop.rd] <= alu_out;
        end
    end

    ////////////////////////////////////////
    // Result port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) result_valid <= 1'b0;
        else     result_valid <= do_emit;
    end

    // Same edge as the register write
    always_ff @(posedge clk) begin
        if (do_emit) begin
            result.data <= op_a;
            result.src  <= uop.ra;  // Tag with the source register
        end
    end

endmodule

`default_nettype wire

// File: verilog/stream_core_top.sv
`default_nettype none

// Memory, decoder and execute stage in a fixed latency pipeline
module stream_core_top
    import stream_core_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  inst_valid,
    output logic       inst_ready,
    input  wire inst_t inst,
    output logic       result_valid,
    output result_t    result
);

    ////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////

    logic  raw_valid;  // Replay out of the RAM
    inst_t raw;
    logic  uop_valid;  // Decoded word
    uop_t  uop;

    // Load burst in, one replay pass out
    inst_mem u_inst_mem (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .raw_valid  (raw_valid),
        .raw        (raw)
    );

    inst_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .raw_valid (raw_valid),
        .raw       (raw),
        .uop_valid (uop_valid),
        .uop       (uop)
    );

    // No stall path, results leave as soon as they are made
    exec_unit u_exec (
        .clk          (clk),
        .rst          (rst),
        .uop_valid    (uop_valid),
        .uop          (uop),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`default_nettype none

// Free running clock and power on reset
module tb_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 20;  // 40 ns clock
    localparam int REL_DLY     = 2;   // Release just after the edge

    initial clk = 1'b0;

    always #HALF_PERIOD clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #REL_DLY;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_stream_core.sv
`default_nettype none

`include "stream_core_cfg.svh"

module tb_stream_core
    import stream_core_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DRV_DLY      = 2;    // ns after the rising edge
    localparam int RESET_CYCLES = 8;
    localparam int NUM_PROGS    = 6;
    localparam int TOTAL_WORDS  = 110;  // Upper bound over all programs
    // Two cycles per word and a gap with pipeline slack per program
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 2 * TOTAL_WORDS
                                + NUM_PROGS * (`IMEM_REPLAY_GAP + 20) + 100;

    logic    clk;
    logic    rst;
    logic    inst_valid;
    logic    inst_ready;
    inst_t   inst;
    logic    result_valid;
    result_t result;

    logic [`DATA_WIDTH-1:0] model_rf [16];  // Expected register file
    result_t exp_q [$];                      // Expected result beats in order
    result_t exp_r;
    string   cur_test;
    int      results_seen;
    int      cycle_cnt = 0;
    integer  seed;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clk (.clk(clk), .rst(rst));

    stream_core_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .inst         (inst),
        .result_valid (result_valid),
        .result       (result)
    );

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input string exp, input string act);
        abort_run($sformatf("[FAIL] %s expected %s actual %s", name, exp, act));
    endtask

    function automatic string show_result(input result_t r);
        return $sformatf("r%0d=%h", r.src, r.data);
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic inst_t make_inst(input logic [3:0] op, input int rd, input int ra,
                                        input int rb, input int imm);
        inst_t w;
        w.op  = op;
        w.rd  = rd[3:0];
        w.ra  = ra[3:0];
        w.rb  = rb[3:0];
        w.imm = imm[`IMM_WIDTH-1:0];  // Truncated to the field
        return w;
    endfunction

    task automatic model_step(input inst_t w);
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] imm_val;
        result_t r;
        a = model_rf[w.ra];
        b = model_rf[w.rb];
        // Two's complement value of the 20 bit field
        imm_val = '0;
        imm_val[`IMM_WIDTH-1:0] = w.imm;
        if (w.imm[`IMM_WIDTH-1]) imm_val = imm_val - (32'd1 << `IMM_WIDTH);
        case (w.op)
            OP_LDI: model_rf[w.rd] = imm_val;
            OP_ADD: model_rf[w.rd] = a + b;
            OP_SUB: model_rf[w.rd] = a - b;
            OP_AND: model_rf[w.rd] = a & b;
            OP_OR:  model_rf[w.rd] = a | b;
            OP_XOR: model_rf[w.rd] = a ^ b;
            OP_SHL: model_rf[w.rd] = a << b[4:0];  // Shift amount mod 32
            OP_OUT: begin
                r.data = a;
                r.src  = w.ra;
                exp_q.push_back(r);
            end
            default: ;  // NOP and illegal codes
        endcase
    endtask

    ////////////////////////////////////////
    // Stimulus and checking
    ////////////////////////////////////////

    // Entered and left at posedge plus DRV_DLY
    task automatic load_program(input inst_t prog[$]);
        int   i;
        logic took;
        foreach (prog[k]) model_step(prog[k]);
        i = 0;
        while (i < prog.size()) begin
            inst_valid = 1'b1;
            inst       = prog[i];
            @(negedge clk);
            took = inst_ready;  // Beat moves at the coming edge
            @(posedge clk);
            #DRV_DLY;
            if (took) i++;
        end
        inst_valid = 1'b0;  // Ends the burst
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || !inst_ready) @(negedge clk);
        repeat (4) @(negedge clk);  // Room for a stray beat
        @(posedge clk);
        #DRV_DLY;
    endtask

    // Results in order against the model queue
    always @(negedge clk) begin
        if (!rst && result_valid) begin
            assert (exp_q.size() != 0) else abort_run("result beat arrived with none expected");
            exp_r = exp_q.pop_front();
            assert (result == exp_r)
                else report_mismatch(cur_test, show_result(exp_r), show_result(result));
            results_seen++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        assert (cycle_cnt < CYCLE_LIMIT)
            else abort_run($sformatf("timeout after %0d cycles", cycle_cnt));
    end

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_ldi_out();
        inst_t prog[$];
        cur_test = "ldi_out";
        prog.push_back(make_inst(OP_LDI, 1, 0, 0, 1234));
        prog.push_back(make_inst(OP_OUT, 0, 1, 0, 0));
        prog.push_back(make_inst(OP_LDI, 2, 0, 0, -524288));  // Most negative imm
        prog.push_back(make_inst(OP_OUT, 0, 2, 0, 0));
        prog.push_back(make_inst(OP_LDI, 15, 0, 0, -7));
        prog.push_back(make_inst(OP_OUT, 0, 15, 0, 0));
        load_program(prog);
        wait_drain();
    endtask

    task automatic test_alu_ops();
        inst_t prog[$];
        cur_test = "alu_ops";
        prog.push_back(make_inst(OP_LDI, 1, 0, 0, -1));
        prog.push_back(make_inst(OP_LDI, 2, 0, 0, 5));
        prog.push_back(make_inst(OP_LDI, 10, 0, 0, $random(seed)));
        prog.push_back(make_inst(OP_LDI, 11, 0, 0, $random(seed)));
        prog.push_back(make_inst(OP_LDI, 6, 0, 0, 31));
        prog.push_back(make_inst(OP_LDI, 8, 0, 0, 33));  // Low bits give 1
        prog.push_back(make_inst(OP_ADD, 3, 1, 2, 0));   // Wraps to 4
        prog.push_back(make_inst(OP_OUT, 0, 3, 0, 0));
        prog.push_back(make_inst(OP_SUB, 4, 0, 2, 0));   // Wraps below zero
        prog.push_back(make_inst(OP_OUT, 0, 4, 0, 0));
        prog.push_back(make_inst(OP_AND, 5, 10, 11, 0));
        prog.push_back(make_inst(OP_OUT, 0, 5, 0, 0));
        prog.push_back(make_inst(OP_OR, 5, 10, 11, 0));
        prog.push_back(make_inst(OP_OUT, 0, 5, 0, 0));
        prog.push_back(make_inst(OP_XOR, 5, 10, 1, 0));
        prog.push_back(make_inst(OP_OUT, 0, 5, 0, 0));
        prog.push_back(make_inst(OP_SHL, 7, 2, 6, 0));
        prog.push_back(make_inst(OP_OUT, 0, 7, 0, 0));
        prog.push_back(make_inst(OP_SHL, 9, 11, 8, 0));
        prog.push_back(make_inst(OP_OUT, 0, 9, 0, 0));
        load_program(prog);
        wait_drain();
    endtask

    // Every word reads the rd of the word before it
    task automatic test_dep_chain();
        inst_t prog[$];
        cur_test = "dep_chain";
        prog.push_back(make_inst(OP_LDI, 1, 0, 0, 3));
        prog.push_back(make_inst(OP_ADD, 2, 1, 1, 0));
        prog.push_back(make_inst(OP_SUB, 3, 2, 1, 0));
        prog.push_back(make_inst(OP_SHL, 4, 3, 3, 0));
        prog.push_back(make_inst(OP_XOR, 5, 4, 2, 0));
        prog.push_back(make_inst(OP_OR, 6, 5, 5, 0));
        prog.push_back(make_inst(OP_AND, 7, 6, 4, 0));
        prog.push_back(make_inst(OP_ADD, 8, 7, 7, 0));
        prog.push_back(make_inst(OP_OUT, 0, 8, 0, 0));
        prog.push_back(make_inst(OP_OUT, 0, 6, 0, 0));
        load_program(prog);
        wait_drain();
    endtask

    task automatic test_ready_reload();
        inst_t prog_a[$];
        inst_t prog_b[$];
        cur_test = "ready_reload";
        prog_a.push_back(make_inst(OP_LDI, 3, 0, 0, 77));
        prog_a.push_back(make_inst(OP_LDI, 5, 0, 0, -1));
        prog_a.push_back(make_inst(OP_OUT, 0, 3, 0, 0));
        prog_a.push_back(make_inst(OP_OUT, 0, 5, 0, 0));
        // Shorter reload that leans on r3 and r5 from the first program
        prog_b.push_back(make_inst(OP_ADD, 4, 3, 5, 0));
        prog_b.push_back(make_inst(OP_OUT, 0, 4, 0, 0));
        load_program(prog_a);
        @(posedge clk);  // Burst end seen here
        @(negedge clk);
        assert (!inst_ready) else abort_run("inst_ready stayed high after the burst ended");
        while (!inst_ready) @(negedge clk);
        wait_drain();
        load_program(prog_b);
        wait_drain();
    endtask

    task automatic test_random_prog();
        inst_t prog[$];
        logic [3:0] op;
        int n_out;
        int base;
        cur_test = "random_prog";
        n_out = 0;
        for (int i = 0; i < 60; i++) begin
            op = (i % 6 == 5) ? OP_OUT : 4'($random(seed));  // Illegal codes included
            if (op == OP_OUT) n_out++;
            prog.push_back(make_inst(op, $random(seed), $random(seed), $random(seed),
                                     $random(seed)));
        end
        base = results_seen;
        load_program(prog);
        // Replay is over once ready falls and rises again
        @(negedge clk);
        while (inst_ready) @(negedge clk);
        while (!inst_ready) @(negedge clk);
        // Last word still passes through decode and execute
        repeat (3) @(negedge clk);
        @(posedge clk);
        #DRV_DLY;
        assert (results_seen - base == n_out)
            else report_mismatch(cur_test, $sformatf("%0d results", n_out),
                                 $sformatf("%0d results", results_seen - base));
    endtask

    initial begin
        seed         = 32'h6835;
        inst_valid   = 1'b0;
        inst         = '0;
        results_seen = 0;
        foreach (model_rf[i]) model_rf[i] = '0;
        @(negedge rst);
        @(posedge clk);
        #DRV_DLY;
        test_ldi_out();
        test_alu_ops();
        test_dep_chain();
        test_ready_reload();
        test_random_prog();
        repeat (10) @(negedge clk);
        if (exp_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            abort_run("expected results never arrived");
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/stream_core_pkg.sv
verilog/sdp_bram.sv
verilog/inst_mem.sv
verilog/inst_decoder.sv
verilog/exec_unit.sv
verilog/stream_core_top.sv
testbench/tb_clock_gen.sv
testbench/tb_stream_core.sv

// File: Bender.yml
package:
  name: stream_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/stream_core_pkg.sv
      - verilog/sdp_bram.sv
      - verilog/inst_mem.sv
      - verilog/inst_decoder.sv
      - verilog/exec_unit.sv
      - verilog/stream_core_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_stream_core.sv
